// ==== logic/cpu_isa_pkg.sv ====
/*
 * Instruction set view of the core: the 32-bit instruction word, opcodes,
 * operand sizes and the flag set. The sequencer, the register file and the
 * ALU refer to these by scoped names.
 */
package cpu_isa_pkg;

    // operation codes carried in the instruction word
    typedef enum logic [3:0] {
        OP_LDI = 4'd0,  // dst <- imm
        OP_LD  = 4'd1,  // dst <- src
        OP_ADD = 4'd2,
        OP_SUB = 4'd3,
        OP_AND = 4'd4,
        OP_OR  = 4'd5,
        OP_XOR = 4'd6,
        OP_LDF = 4'd7,  // bank pointer <- imm[1:0]
        OP_EXF = 4'd8   // swap main and alternate flags
    } opcode_t;

    // operand size of a register access
    typedef enum logic [1:0] {
        SZ_B = 2'd0,    // low byte
        SZ_W = 2'd1,    // low half
        SZ_L = 2'd2     // full 32 bits
    } size_t;

    // instruction word, imm sits in the low half
    typedef struct packed {
        logic [3:0]  rsv;
        logic [2:0]  src;     // bit 2 set selects a pointer
        logic [2:0]  dst;
        size_t       size;
        opcode_t     opcode;
        logic [15:0] imm;
    } instr_t;

    // status flags, same order in the main and the alternate set
    typedef struct packed {
        logic s;    // sign
        logic z;    // zero
        logic h;    // half carry
        logic v;    // overflow or parity
        logic n;    // subtract
        logic c;    // carry
    } flags_t;

endpackage

// ==== logic/cpu_ctrl_pkg.sv ====
/*
 * Microcode control word issued by the sequencer once per cycle, with the
 * select codes that steer the register file and the ALU.
 */
package cpu_ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,    // forward op0
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5
    } alu_op_t;

    // register address latch load
    typedef enum logic [1:0] {
        RAL_NONE = 2'd0,
        RAL_SRC  = 2'd1,
        RAL_DST  = 2'd2,
        RAL_BOTH = 2'd3
    } ral_sel_t;

    // operand register load
    typedef enum logic [1:0] {
        OPND_NONE = 2'd0,
        OPND_SRC  = 2'd1,   // op0 <- source register
        OPND_DST  = 2'd2,   // op1 <- destination register
        OPND_IMM  = 2'd3    // op0 <- immediate held in md
    } opnd_sel_t;

    // write-back target
    typedef enum logic [1:0] {
        LD_NONE = 2'd0,
        LD_DST  = 2'd1,
        LD_RFP  = 2'd2
    } ld_sel_t;

    // flag update
    typedef enum logic [1:0] {
        CC_NONE  = 2'd0,
        CC_ARITH = 2'd1,
        CC_LOGIC = 2'd2,
        CC_EXF   = 2'd3
    } cc_sel_t;

    typedef struct packed {
        logic                fetch;     // md <- din
        logic                inc_pc;
        ral_sel_t            ral_sel;
        opnd_sel_t           opnd_sel;
        alu_op_t             alu_op;
        ld_sel_t             ld_sel;
        cc_sel_t             cc_sel;
        cpu_isa_pkg::size_t  size;
    } uctrl_t;

endpackage

// ==== logic/cpu_ucode.sv ====
/*
 * Microcode sequencer. Accepts an instruction with a start pulse while idle
 * and walks it through fixed steps, one control word per enabled cycle.
 * Register operations take steps 1 to 4, OP_LDF and OP_EXF end at step 2.
 */
`timescale 1ns/1ps

module cpu_ucode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic                  start,
    input  cpu_isa_pkg::instr_t   md,
    output logic                  busy,
    output logic                  done,
    output cpu_ctrl_pkg::uctrl_t  uctrl
);

logic [2:0]            step;
logic                  short_op;    // finishes in step 2
logic                  last;
cpu_ctrl_pkg::alu_op_t exe_op;
cpu_ctrl_pkg::cc_sel_t exe_cc;

// opcode decode, only the step 4 word uses exe_cc
always_comb begin
    short_op = 1'b0;
    exe_op   = cpu_ctrl_pkg::ALU_PASS;
    exe_cc   = cpu_ctrl_pkg::CC_NONE;
    case (md.opcode)
        cpu_isa_pkg::OP_LDI,
        cpu_isa_pkg::OP_LD:  exe_op = cpu_ctrl_pkg::ALU_PASS;
        cpu_isa_pkg::OP_ADD: begin
            exe_op = cpu_ctrl_pkg::ALU_ADD;
            exe_cc = cpu_ctrl_pkg::CC_ARITH;
        end
        cpu_isa_pkg::OP_SUB: begin
            exe_op = cpu_ctrl_pkg::ALU_SUB;
            exe_cc = cpu_ctrl_pkg::CC_ARITH;
        end
        cpu_isa_pkg::OP_AND: begin
            exe_op = cpu_ctrl_pkg::ALU_AND;
            exe_cc = cpu_ctrl_pkg::CC_LOGIC;
        end
        cpu_isa_pkg::OP_OR: begin
            exe_op = cpu_ctrl_pkg::ALU_OR;
            exe_cc = cpu_ctrl_pkg::CC_LOGIC;
        end
        cpu_isa_pkg::OP_XOR: begin
            exe_op = cpu_ctrl_pkg::ALU_XOR;
            exe_cc = cpu_ctrl_pkg::CC_LOGIC;
        end
        default: short_op = 1'b1;   // LDF, EXF and unused codes
    endcase
    last = short_op ? (step == 3'd2) : (step == 3'd4);
end

assign done = busy & last & cen;

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        busy <= 1'b0;
        step <= 3'd0;
    end else if (cen) begin
        if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                step <= 3'd1;
            end
        end else if (last) begin
            busy <= 1'b0;
            step <= 3'd0;
        end else begin
            step <= step + 3'd1;
        end
    end
end

// control word table, indexed by step and opcode
always_comb begin
    uctrl        = '0;
    uctrl.size   = md.size;
    uctrl.alu_op = exe_op;
    if (!busy) begin
        uctrl.fetch = start;    // start while busy is ignored
    end else begin
        case (step)
            3'd1: begin
                uctrl.ral_sel = cpu_ctrl_pkg::RAL_BOTH;
                uctrl.inc_pc  = 1'b1;
            end
            3'd2: begin
                if (md.opcode == cpu_isa_pkg::OP_LDF)
                    uctrl.ld_sel = cpu_ctrl_pkg::LD_RFP;
                else if (md.opcode == cpu_isa_pkg::OP_EXF)
                    uctrl.cc_sel = cpu_ctrl_pkg::CC_EXF;
                else if (md.opcode == cpu_isa_pkg::OP_LDI)
                    uctrl.opnd_sel = cpu_ctrl_pkg::OPND_IMM;
                else if (!short_op)
                    uctrl.opnd_sel = cpu_ctrl_pkg::OPND_SRC;
            end
            3'd3: uctrl.opnd_sel = cpu_ctrl_pkg::OPND_DST;
            3'd4: begin
                uctrl.ld_sel = cpu_ctrl_pkg::LD_DST;
                uctrl.cc_sel = exe_cc;
            end
            default: ;
        endcase
    end
end

endmodule

// ==== logic/cpu_regs.sv ====
/*
 * Register file of the core: four banks of four general registers, four
 * pointers (pointer 3 is the stack pointer), main and alternate flags, the
 * bank pointer, pc, md, the register address latches and op0/op1.
 * All loads follow the control word from the sequencer. Byte-wide dump port.
 */
`timescale 1ns/1ps

module cpu_regs #(
    parameter logic [31:0] XSP_RESET = 32'h100
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  cpu_isa_pkg::instr_t   din,
    input  cpu_ctrl_pkg::uctrl_t  uctrl,
    input  logic [31:0]           rslt,
    input  cpu_isa_pkg::flags_t   alu_flags,
    output cpu_isa_pkg::instr_t   md,
    output logic [31:0]           op0,
    output logic [31:0]           op1,
    output cpu_isa_pkg::flags_t   flags,
    output logic [23:0]           pc,
    input  logic [7:0]            dmp_addr,
    output logic [7:0]            dmp_dout
);

localparam int         NUM_REGS = 20;     // 16 general + 4 pointers
localparam logic [4:0] XSP_IDX  = 5'd19;

logic [31:0]         rf [0:NUM_REGS-1];
cpu_isa_pkg::flags_t flags_alt;
logic [1:0]          rfp;                 // bank pointer
logic [4:0]          src, dst;            // latched register indexes
logic [31:0]         dmp_word;

// 3-bit field to file index, pointers live at 16..19 and ignore the bank
function automatic logic [4:0] reg_idx(input logic [2:0] field, input logic [1:0] bank);
    return field[2] ? {3'b100, field[1:0]} : {1'b0, bank, field[1:0]};
endfunction

// sized read keeps the low part only
function automatic logic [31:0] size_cut(input logic [31:0] value,
                                         input cpu_isa_pkg::size_t size);
    case (size)
        cpu_isa_pkg::SZ_B: return {24'd0, value[7:0]};
        cpu_isa_pkg::SZ_W: return {16'd0, value[15:0]};
        default:           return value;
    endcase
endfunction

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        for (int i = 0; i < NUM_REGS; i++)
            rf[i] <= '0;
        rf[XSP_IDX] <= XSP_RESET;
        flags     <= '0;
        flags_alt <= '0;
        rfp       <= 2'd0;
        pc        <= 24'd0;
        md        <= '0;
        src       <= 5'd0;
        dst       <= 5'd0;
        op0       <= 32'd0;
        op1       <= 32'd0;
    end else if (cen) begin
        if (uctrl.fetch)
            md <= din;
        if (uctrl.inc_pc)
            pc <= pc + 24'd1;

        case (uctrl.ral_sel)
            cpu_ctrl_pkg::RAL_SRC:  src <= reg_idx(md.src, rfp);
            cpu_ctrl_pkg::RAL_DST:  dst <= reg_idx(md.dst, rfp);
            cpu_ctrl_pkg::RAL_BOTH: begin
                src <= reg_idx(md.src, rfp);
                dst <= reg_idx(md.dst, rfp);
            end
            default: ;
        endcase

        case (uctrl.opnd_sel)
            cpu_ctrl_pkg::OPND_SRC: op0 <= size_cut(rf[src], uctrl.size);
            cpu_ctrl_pkg::OPND_DST: op1 <= size_cut(rf[dst], uctrl.size);
            cpu_ctrl_pkg::OPND_IMM: op0 <= size_cut({16'd0, md.imm}, uctrl.size);
            default: ;
        endcase

        case (uctrl.ld_sel)
            cpu_ctrl_pkg::LD_DST: begin
                case (uctrl.size)   // upper part of dst is kept
                    cpu_isa_pkg::SZ_B: rf[dst][7:0]  <= rslt[7:0];
                    cpu_isa_pkg::SZ_W: rf[dst][15:0] <= rslt[15:0];
                    default:           rf[dst]       <= rslt;
                endcase
            end
            cpu_ctrl_pkg::LD_RFP: rfp <= md.imm[1:0];
            default: ;
        endcase

        case (uctrl.cc_sel)
            cpu_ctrl_pkg::CC_ARITH: flags <= alu_flags;
            cpu_ctrl_pkg::CC_LOGIC: begin
                flags <= {alu_flags.s, alu_flags.z, alu_flags.h, alu_flags.v, 2'b00};
            end
            cpu_ctrl_pkg::CC_EXF: begin
                flags     <= flags_alt;
                flags_alt <= flags;
            end
            default: ;
        endcase
    end
end

// dump port, 4 bytes per register, bank pointer and flags at 80/81
always_comb begin
    dmp_word = '0;
    if (dmp_addr[6:2] < NUM_REGS)
        dmp_word = rf[dmp_addr[6:2]];
    if (dmp_addr == 8'd80)
        dmp_dout = {6'd0, rfp};
    else if (dmp_addr == 8'd81)
        dmp_dout = {2'd0, flags};
    else
        dmp_dout = dmp_word[{dmp_addr[1:0], 3'b000} +: 8];
end

endmodule

// ==== logic/cpu_alu.sv ====
/*
 * Combinational ALU. Computes op1 <op> op0 at byte, word or long size and
 * the flag candidates for that size. The register file picks which flags
 * are kept.
 */
`timescale 1ns/1ps

module cpu_alu (
    input  cpu_ctrl_pkg::alu_op_t  alu_op,
    input  cpu_isa_pkg::size_t     size,
    input  logic [31:0]            op0,
    input  logic [31:0]            op1,
    output logic [31:0]            rslt,
    output cpu_isa_pkg::flags_t    alu_flags
);

logic [32:0] sum, diff;
logic [4:0]  hsum, hdiff;     // nibble carry and borrow
logic [31:0] res, mask;
logic        top_a, top_b, top_r, cout;

always_comb begin
    sum   = {1'b0, op1} + {1'b0, op0};
    diff  = {1'b0, op1} - {1'b0, op0};
    hsum  = {1'b0, op1[3:0]} + {1'b0, op0[3:0]};
    hdiff = {1'b0, op1[3:0]} - {1'b0, op0[3:0]};

    case (alu_op)
        cpu_ctrl_pkg::ALU_ADD: res = sum[31:0];
        cpu_ctrl_pkg::ALU_SUB: res = diff[31:0];
        cpu_ctrl_pkg::ALU_AND: res = op1 & op0;
        cpu_ctrl_pkg::ALU_OR:  res = op1 | op0;
        cpu_ctrl_pkg::ALU_XOR: res = op1 ^ op0;
        default:               res = op0;
    endcase

    // operands arrive zero-extended, so the bit above the size is carry out
    case (size)
        cpu_isa_pkg::SZ_B: begin
            mask  = 32'h0000_00ff;
            top_a = op1[7];
            top_b = op0[7];
            top_r = res[7];
            cout  = (alu_op == cpu_ctrl_pkg::ALU_SUB) ? diff[8] : sum[8];
        end
        cpu_isa_pkg::SZ_W: begin
            mask  = 32'h0000_ffff;
            top_a = op1[15];
            top_b = op0[15];
            top_r = res[15];
            cout  = (alu_op == cpu_ctrl_pkg::ALU_SUB) ? diff[16] : sum[16];
        end
        default: begin
            mask  = 32'hffff_ffff;
            top_a = op1[31];
            top_b = op0[31];
            top_r = res[31];
            cout  = (alu_op == cpu_ctrl_pkg::ALU_SUB) ? diff[32] : sum[32];
        end
    endcase

    rslt        = res & mask;
    alu_flags   = '0;
    alu_flags.s = top_r;
    alu_flags.z = (rslt == 32'd0);
    case (alu_op)
        cpu_ctrl_pkg::ALU_ADD: begin
            alu_flags.h = hsum[4];
            alu_flags.c = cout;
            alu_flags.v = (top_a == top_b) && (top_r != top_a);
        end
        cpu_ctrl_pkg::ALU_SUB: begin
            alu_flags.h = hdiff[4];
            alu_flags.c = cout;     // borrow
            alu_flags.v = (top_a != top_b) && (top_r != top_a);
            alu_flags.n = 1'b1;
        end
        cpu_ctrl_pkg::ALU_AND,
        cpu_ctrl_pkg::ALU_OR,
        cpu_ctrl_pkg::ALU_XOR: begin
            alu_flags.v = ~^rslt[7:0];  // even parity
            alu_flags.h = (alu_op == cpu_ctrl_pkg::ALU_AND);
        end
        default: ;
    endcase
end

endmodule

// ==== logic/cpu_core.sv ====
/*
 * Execution core top level. Connects the microcode sequencer, the register
 * file and the ALU. XSP_RESET sets the stack pointer after reset.
 */
`timescale 1ns/1ps

module cpu_core #(
    parameter logic [31:0] XSP_RESET = 32'h100
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  logic                 start,
    input  cpu_isa_pkg::instr_t  din,
    input  logic [7:0]           dmp_addr,
    output logic                 busy,
    output logic                 done,
    output cpu_isa_pkg::flags_t  flags,
    output logic [23:0]          pc,
    output logic [7:0]           dmp_dout
);

cpu_ctrl_pkg::uctrl_t uctrl;
cpu_isa_pkg::instr_t  md;
cpu_isa_pkg::flags_t  alu_flags;
logic [31:0]          op0, op1, rslt;

cpu_ucode u_ucode (
    .clk   (clk),
    .rst   (rst),
    .cen   (cen),
    .start (start),
    .md    (md),
    .busy  (busy),
    .done  (done),
    .uctrl (uctrl)
);

cpu_regs #(
    .XSP_RESET (XSP_RESET)
) u_regs (
    .clk       (clk),
    .rst       (rst),
    .cen       (cen),
    .din       (din),
    .uctrl     (uctrl),
    .rslt      (rslt),
    .alu_flags (alu_flags),
    .md        (md),
    .op0       (op0),
    .op1       (op1),
    .flags     (flags),
    .pc        (pc),
    .dmp_addr  (dmp_addr),
    .dmp_dout  (dmp_dout)
);

cpu_alu u_alu (
    .alu_op    (uctrl.alu_op),
    .size      (uctrl.size),
    .op0       (op0),
    .op1       (op1),
    .rslt      (rslt),
    .alu_flags (alu_flags)
);

endmodule

// ==== tb/tb_clkgen.sv ====
/*
 * Testbench clock and reset source. 20 ns clock, reset held high for the
 * first 3 rising edges and released just after the third.
 */
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;  // off the edge, like the other inputs
end

endmodule

// ==== tb/cpu_core_assertions.sv ====
/*
 * Shadow model of the register file, flags, bank pointer and pc, advanced
 * from din when the core accepts an instruction. Concurrent assertions
 * compare the idle core and its dump port with the model. Bound to cpu_core.
 */
`timescale 1ns/1ps

module cpu_core_assertions #(
    parameter logic [31:0] XSP_RESET = 32'h100
) (
    input logic                clk,
    input logic                rst,
    input logic                cen,
    input logic                start,
    input cpu_isa_pkg::instr_t din,
    input logic [7:0]          dmp_addr,
    input logic                busy,
    input logic                done,
    input cpu_isa_pkg::flags_t flags,
    input logic [23:0]         pc,
    input logic [7:0]          dmp_dout
);

int                  errors = 0;
logic [31:0]         sh_rf [0:19];     // 16 general, then 4 pointers
cpu_isa_pkg::flags_t sh_flags, sh_alt;
logic [1:0]          sh_rfp;
logic [23:0]         sh_pc;
int                  lat, lat_exp;     // cycles since start, expected at done
logic                accept, short_op;
int                  d_idx, s_idx, w;
logic [31:0]         mask, opa, opb, p_rslt, wr_val;
cpu_isa_pkg::flags_t p_flags;
logic [7:0]          exp_dump;

// field with bit 2 set picks a shared pointer, otherwise a reg of the bank
function automatic int reg_index(input logic [2:0] field, input logic [1:0] bank);
    return field[2] ? 16 + int'(field[1:0]) : 4 * int'(bank) + int'(field[1:0]);
endfunction

function automatic int width_of(input cpu_isa_pkg::size_t sz);
    return (sz == cpu_isa_pkg::SZ_B) ? 8 : (sz == cpu_isa_pkg::SZ_W) ? 16 : 32;
endfunction

// a is the destination operand, b the source or immediate, both sized
function automatic void predict(input cpu_isa_pkg::opcode_t op, input int wd,
                                input logic [31:0] a, input logic [31:0] b,
                                output logic [31:0] r, output cpu_isa_pkg::flags_t f);
    logic [63:0] full;
    logic        sa, sb, sr;
    f = '0;
    case (op)
        cpu_isa_pkg::OP_ADD: full = {32'd0, a} + {32'd0, b};
        cpu_isa_pkg::OP_SUB: full = {32'd0, a} - {32'd0, b};   // wraps, bit wd is borrow
        cpu_isa_pkg::OP_AND: full = {32'd0, a & b};
        cpu_isa_pkg::OP_OR:  full = {32'd0, a | b};
        cpu_isa_pkg::OP_XOR: full = {32'd0, a ^ b};
        default:             full = {32'd0, b};
    endcase
    r  = full[31:0] & (32'hffff_ffff >> (32 - wd));
    sa = a[wd-1];
    sb = b[wd-1];
    sr = r[wd-1];
    f.s = sr;
    f.z = (r == 32'd0);
    if (op == cpu_isa_pkg::OP_ADD) begin
        f.c = full[wd];
        f.h = (5'(a[3:0]) + 5'(b[3:0])) > 5'd15;
        f.v = (sa == sb) && (sr != sa);
    end else if (op == cpu_isa_pkg::OP_SUB) begin
        f.c = full[wd];
        f.h = a[3:0] < b[3:0];
        f.v = (sa != sb) && (sr != sa);
        f.n = 1'b1;
    end else begin
        f.v = ($countones(r[7:0]) % 2) == 0;
        f.h = (op == cpu_isa_pkg::OP_AND);
    end
endfunction

assign accept   = start && !busy && cen;
assign short_op = (din.opcode == cpu_isa_pkg::OP_LDF) || (din.opcode == cpu_isa_pkg::OP_EXF);

always_comb begin
    d_idx  = reg_index(din.dst, sh_rfp);
    s_idx  = reg_index(din.src, sh_rfp);
    w      = width_of(din.size);
    mask   = 32'hffff_ffff >> (32 - w);
    opa    = sh_rf[d_idx] & mask;
    opb    = (din.opcode == cpu_isa_pkg::OP_LDI) ? ({16'd0, din.imm} & mask)
                                                 : (sh_rf[s_idx] & mask);
    predict(din.opcode, w, opa, opb, p_rslt, p_flags);
    wr_val = (sh_rf[d_idx] & ~mask) | p_rslt;   // upper part survives
end

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        for (int i = 0; i < 20; i++)
            sh_rf[i] <= (i == 19) ? XSP_RESET : 32'd0;
        sh_flags <= '0;
        sh_alt   <= '0;
        sh_rfp   <= 2'd0;
        sh_pc    <= 24'd0;
        lat      <= 0;
        lat_exp  <= 0;
    end else if (accept) begin
        sh_pc   <= sh_pc + 24'd1;
        lat     <= 1;
        lat_exp <= short_op ? 2 : 4;
        case (din.opcode)
            cpu_isa_pkg::OP_LDF: sh_rfp <= din.imm[1:0];
            cpu_isa_pkg::OP_EXF: begin
                sh_flags <= sh_alt;
                sh_alt   <= sh_flags;
            end
            default: begin
                sh_rf[d_idx] <= wr_val;
                if (din.opcode != cpu_isa_pkg::OP_LD && din.opcode != cpu_isa_pkg::OP_LDI)
                    sh_flags <= p_flags;
            end
        endcase
    end else if (busy && cen) begin
        lat <= lat + 1;
    end
end

always_comb begin
    if (dmp_addr == 8'd80)
        exp_dump = {6'd0, sh_rfp};
    else if (dmp_addr == 8'd81)
        exp_dump = {2'd0, sh_flags};
    else
        exp_dump = sh_rf[dmp_addr[6:2]][{dmp_addr[1:0], 3'b000} +: 8];
end

a_latency: assert property (@(posedge clk) disable iff (rst) done |-> lat == lat_exp)
    else begin
        $error("Mismatch at %0t: done after %0d cycles, expected %0d", $time, lat, lat_exp);
        errors++;
    end

a_pc: assert property (@(posedge clk) disable iff (rst) !busy |-> pc == sh_pc)
    else begin
        $error("Mismatch at %0t: pc %0h, expected %0h", $time, pc, sh_pc);
        errors++;
    end

a_flags: assert property (@(posedge clk) disable iff (rst) !busy |-> flags == sh_flags)
    else begin
        $error("Mismatch at %0t: flags %b, expected %b", $time, flags, sh_flags);
        errors++;
    end

a_dump: assert property (@(posedge clk) disable iff (rst)
                         (!busy && dmp_addr <= 8'd81) |-> dmp_dout == exp_dump)
    else begin
        $error("Mismatch at %0t: dump[%0d] %h, expected %h", $time, dmp_addr,
               dmp_dout, exp_dump);
        errors++;
    end

endmodule

bind cpu_core cpu_core_assertions #(
    .XSP_RESET (XSP_RESET)
) u_assert (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .start    (start),
    .din      (din),
    .dmp_addr (dmp_addr),
    .busy     (busy),
    .done     (done),
    .flags    (flags),
    .pc       (pc),
    .dmp_dout (dmp_dout)
);

// ==== tb/tb_top.sv ====
/*
 * Testbench top. Issues directed and random instructions to the core and
 * sweeps the dump port so that the bound assertions see every register.
 * Prints the error counts and the verdict at the end of the run.
 */
`timescale 1ns/1ps

module tb_top;

localparam logic [31:0] XSP_RESET = 32'h0012_3400;

logic                clk, rst;
logic                cen, start;
cpu_isa_pkg::instr_t din;
logic [7:0]          dmp_addr;
logic                busy, done;
cpu_isa_pkg::flags_t flags;
logic [23:0]         pc;
logic [7:0]          dmp_dout;
int                  timeouts = 0;
int                  total;
int                  rst_wait;

tb_clkgen u_clkgen (
    .clk (clk),
    .rst (rst)
);

cpu_core #(
    .XSP_RESET (XSP_RESET)
) u_cpu_core (
    .clk      (clk),
    .rst      (rst),
    .cen      (cen),
    .start    (start),
    .din      (din),
    .dmp_addr (dmp_addr),
    .busy     (busy),
    .done     (done),
    .flags    (flags),
    .pc       (pc),
    .dmp_dout (dmp_dout)
);

function automatic cpu_isa_pkg::instr_t make_instr(input cpu_isa_pkg::opcode_t op,
                                                   input cpu_isa_pkg::size_t sz,
                                                   input logic [2:0] dst,
                                                   input logic [2:0] src,
                                                   input logic [15:0] imm);
    cpu_isa_pkg::instr_t ins;
    ins        = '0;
    ins.opcode = op;
    ins.size   = sz;
    ins.dst    = dst;
    ins.src    = src;
    ins.imm    = imm;
    return ins;
endfunction

// LDI, LD or an ALU op with random size, registers and immediate
function automatic cpu_isa_pkg::instr_t random_reg_instr();
    return make_instr(cpu_isa_pkg::opcode_t'(4'($urandom % 7)),
                      cpu_isa_pkg::size_t'(2'($urandom % 3)),
                      3'($urandom), 3'($urandom), 16'($urandom));
endfunction

// start one instruction, optionally pulse start again while busy
task automatic execute(input cpu_isa_pkg::instr_t ins, input bit poke);
    int waited;
    start = 1'b1;
    din   = ins;
    @(posedge clk);
    #1;
    if (poke) begin
        din = cpu_isa_pkg::instr_t'($urandom);  // must be ignored
        @(posedge clk);
        #1;
    end
    start  = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!done && waited < 20) begin
        @(negedge clk);
        waited++;
    end
    if (!done) begin
        timeouts++;
        $display("Timeout at %0t: no done within 20 cycles of start", $time);
    end
    @(posedge clk);
    #1;
endtask

task automatic dump_sweep();
    for (int a = 0; a <= 81; a++) begin
        dmp_addr = 8'(a);
        @(posedge clk);
        #1;
    end
endtask

initial begin
    void'($urandom(32'h6902));
    cen      = 1'b1;
    start    = 1'b0;
    din      = '0;
    dmp_addr = 8'd76;   // low byte of the stack pointer
    rst_wait = 0;
    @(posedge clk);
    while (rst && rst_wait < 10) begin
        @(posedge clk);
        rst_wait++;
    end
    if (rst)
        $display("Reset still high after 10 cycles");
    if (rst)
        timeouts++;
    #1;
    dump_sweep();

    // word add that sets z, c and v, then swap with the untouched alternate set
    execute(make_instr(cpu_isa_pkg::OP_LDI, cpu_isa_pkg::SZ_L, 3'd0, 3'd0, 16'h8000), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_ADD, cpu_isa_pkg::SZ_W, 3'd0, 3'd0, 16'h0), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_EXF, cpu_isa_pkg::SZ_L, 3'd0, 3'd0, 16'h0), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_EXF, cpu_isa_pkg::SZ_L, 3'd0, 3'd0, 16'h0), 1'b1);

    // all ones in r2, then byte and word writes touch only the low part
    execute(make_instr(cpu_isa_pkg::OP_LDI, cpu_isa_pkg::SZ_L, 3'd3, 3'd0, 16'h0001), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_SUB, cpu_isa_pkg::SZ_L, 3'd2, 3'd3, 16'h0), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_LDI, cpu_isa_pkg::SZ_B, 3'd2, 3'd0, 16'h1234), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_LD,  cpu_isa_pkg::SZ_W, 3'd1, 3'd2, 16'h0), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_LD,  cpu_isa_pkg::SZ_B, 3'd7, 3'd2, 16'h0), 1'b1);

    // bank 1 gets its own r0, the pointer write is seen from bank 0 too
    execute(make_instr(cpu_isa_pkg::OP_LDF, cpu_isa_pkg::SZ_L, 3'd0, 3'd0, 16'h0001), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_LDI, cpu_isa_pkg::SZ_L, 3'd0, 3'd0, 16'hbeef), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_LDI, cpu_isa_pkg::SZ_L, 3'd4, 3'd0, 16'h5a5a), 1'b0);
    execute(make_instr(cpu_isa_pkg::OP_LDF, cpu_isa_pkg::SZ_L, 3'd0, 3'd0, 16'h0000), 1'b0);
    dump_sweep();

    for (int i = 0; i < 120; i++) begin
        if (i % 9 == 8)
            execute(make_instr(cpu_isa_pkg::OP_LDF, cpu_isa_pkg::SZ_L, 3'd0, 3'd0,
                               16'($urandom)), 1'b0);
        else if (i % 13 == 12)
            execute(make_instr(cpu_isa_pkg::OP_EXF, cpu_isa_pkg::SZ_L, 3'd0, 3'd0,
                               16'h0), (i % 2) == 0);
        else
            execute(random_reg_instr(), (i % 5) == 0);
        dmp_addr = 8'($urandom % 82);
    end
    dump_sweep();

    total = u_cpu_core.u_assert.errors + timeouts;
    $display("Errors: %0d assertion, %0d timeout, %0d total",
             u_cpu_core.u_assert.errors, timeouts, total);
    if (total == 0)
        $display("Test OK");
    else
        $display("Test FAILED");
    $finish;
end

endmodule

// ==== flist.f ====
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/cpu_ucode.sv
logic/cpu_regs.sv
logic/cpu_alu.sv
logic/cpu_core.sv
tb/tb_clkgen.sv
tb/cpu_core_assertions.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; fails on a failing run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f

./obj_dir/Vtb_top +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
